/* tests/exec_unit_testdata.txt */
# columns in hex: instr load_word wb_reg wb_value illegal v0_after
# anything after the sixth column is a note
24081234 00000000 08 00001234 0 00000000  # addiu r8, r0, 0x1234
3409f0f0 00000000 09 0000f0f0 0 00000000  # ori r9, r0, 0xf0f0
3c0a8000 00000000 0a 80000000 0 00000000  # lui r10, 0x8000
240bfffe 00000000 0b fffffffe 0 00000000  # addiu r11, r0, -2
25020001 00000000 02 00001235 0 00001235  # addiu r2, r8, 1
01096021 00000000 0c 00010324 0 00001235  # addu r12, r8, r9
01096823 00000000 0d ffff2144 0 00001235  # subu r13, r8, r9
01897024 00000000 0e 00000020 0 00001235  # and r14, r12, r9
01487825 00000000 0f 80001234 0 00001235  # or r15, r10, r8
01691026 00000000 02 ffff0f0e 0 ffff0f0e  # xor r2, r11, r9
0168802a 00000000 10 00000001 0 ffff0f0e  # slt r16, r11, r8
010b882a 00000000 11 00000000 0 ffff0f0e  # slt r17, r8, r11
014b902a 00000000 12 00000001 0 ffff0f0e  # slt r18, r10, r11
25000005 00000000 00 00001239 0 ffff0f0e  # addiu r0, r8, 5
00089821 00000000 13 00001234 0 ffff0f0e  # addu r19, r0, r8
8c140000 11223344 14 11223344 0 ffff0f0e  # lw r20, 0(r0)
88140001 aabbccdd 14 bbccdd44 0 ffff0f0e  # lwl r20, 1(r0)
88140002 55667788 14 7788dd44 0 ffff0f0e  # lwl r20, 2(r0)
88140003 99aabbcc 14 cc88dd44 0 ffff0f0e  # lwl r20, 3(r0)
88140000 01020304 14 01020304 0 ffff0f0e  # lwl r20, 0(r0)
98140000 aabbccdd 14 010203aa 0 ffff0f0e  # lwr r20, 0(r0)
98140001 55667788 14 01025566 0 ffff0f0e  # lwr r20, 1(r0)
98140002 99aabbcc 14 0199aabb 0 ffff0f0e  # lwr r20, 2(r0)
98140003 deadbeef 14 deadbeef 0 ffff0f0e  # lwr r20, 3(r0)
ac140000 00000000 00 00000000 1 ffff0f0e  # sw r20, 0(r0), illegal opcode
0109a020 00000000 00 00000000 1 ffff0f0e  # add r20, r8, r9, illegal funct
02801025 00000000 02 deadbeef 0 deadbeef  # or r2, r20, r0

/* exec_unit.f */
hdl/exec_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/load_merge.sv
hdl/exec_ctrl.sv
hdl/exec_unit.sv
tests/clk_gen.sv
tests/exec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module exec_unit_tb -f exec_unit.f -Mdir obj_dir || exit 1
out=$(./obj_dir/Vexec_unit_tb)
echo "$out"
echo "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1

/* tests/exec_unit_tb.sv */
`timescale 1ns/1ns

module exec_unit_tb;
	import exec_pkg::*;

	localparam int max_lines       = 64;
	localparam int cycles_per_line = 40;

	logic      clk;
	logic      reset;
	logic      in_valid;
	logic      in_ready;
	word_t     in_instr;
	word_t     in_load_word;
	logic      wb_valid;
	logic      wb_ready = 1'b0;
	reg_addr_t wb_reg;
	word_t     wb_value;
	logic      wb_illegal;
	word_t     v0;

	word_t     instr_data  [max_lines];
	word_t     load_data   [max_lines];
	reg_addr_t exp_reg     [max_lines];
	word_t     exp_value   [max_lines];
	logic      exp_illegal [max_lines];
	word_t     exp_v0      [max_lines];

	int   n_lines       = 0;
	logic loaded        = 1'b0;
	int   wb_count      = 0;
	int   v0_index      = -1;
	int   mismatches    = 0;
	int   extra_records = 0;
	int   run_errors    = 0;
	int   seed          = 32'ha05e43ef;

	clk_gen clk_i (.clk, .reset);

	exec_unit dut_i (
		.clk,
		.reset,
		.in_valid,
		.in_ready,
		.in_instr,
		.in_load_word,
		.wb_valid,
		.wb_ready,
		.wb_reg,
		.wb_value,
		.wb_illegal,
		.v0
	);

	// ------------------------------------------------------------------
	// test vectors
	// ------------------------------------------------------------------
	task automatic read_testdata();
		int    fd;
		int    fields;
		string line;
		word_t f_instr;
		word_t f_load;
		word_t f_reg;
		word_t f_value;
		word_t f_illegal;
		word_t f_v0;
		fd = $fopen("tests/exec_unit_testdata.txt", "r");
		if (fd == 0) begin
			run_errors++;
			$display("could not open tests/exec_unit_testdata.txt");
			return;
		end
		while (!$feof(fd) && n_lines < max_lines) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%h %h %h %h %h %h",
					f_instr, f_load, f_reg, f_value, f_illegal, f_v0);
				if (fields != 6) begin
					run_errors++;
					$display("malformed line in test data: %s", line);
				end else begin
					instr_data[n_lines]  = f_instr;
					load_data[n_lines]   = f_load;
					exp_reg[n_lines]     = f_reg[4:0];
					exp_value[n_lines]   = f_value;
					exp_illegal[n_lines] = f_illegal[0];
					exp_v0[n_lines]      = f_v0;
					n_lines++;
				end
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------------
	// input side
	// ------------------------------------------------------------------
	task automatic send_instr(input int idx);
		int latency;
		@(negedge clk);
		in_valid     = 1'b1;
		in_instr     = instr_data[idx];
		in_load_word = load_data[idx];
		while (!in_ready) begin
			@(negedge clk);
		end
		@(negedge clk); // taken on the last rising edge.
		in_valid = 1'b0;
		latency  = 0;
		while (!wb_valid) begin
			@(negedge clk);
			latency++;
		end
		assert (latency == 2) else begin
			run_errors++;
			$display("instruction %0d: wb_valid rose %0d cycles after acceptance instead of 2",
				idx, latency);
		end
	endtask

	// ------------------------------------------------------------------
	// output side with random back-pressure
	// ------------------------------------------------------------------
	task automatic expect_equal(input string what, input int idx, input word_t got,
			input word_t want);
		assert (got == want) else begin
			mismatches++;
			$display("mismatch at %0t: record %0d %s is %h, expected %h",
				$time, idx, what, got, want);
		end
	endtask

	always begin
		@(negedge clk);
		wb_ready = (($random(seed) & 32'd3) != 32'd0); // ready 3 cycles in 4.
		if (v0_index >= 0) begin
			expect_equal("v0", v0_index, v0, exp_v0[v0_index]);
			v0_index = -1;
		end
		if (wb_valid === 1'b1 && wb_ready) begin
			assert (wb_count < n_lines) else begin
				extra_records++;
				$display("unexpected write-back record at %0t", $time);
			end
			if (wb_count < n_lines) begin
				expect_equal("wb_reg", wb_count, 32'(wb_reg), 32'(exp_reg[wb_count]));
				expect_equal("wb_value", wb_count, wb_value, exp_value[wb_count]);
				expect_equal("wb_illegal", wb_count, 32'(wb_illegal),
					32'(exp_illegal[wb_count]));
				v0_index = wb_count; // write lands on the next edge.
				wb_count++;
			end
		end
	end

	initial begin
		in_valid     = 1'b0;
		in_instr     = '0;
		in_load_word = '0;
		read_testdata();
		loaded = 1'b1;
		@(negedge reset);
		for (int i = 0; i < n_lines; i++) begin
			send_instr(i);
		end
		while (wb_count < n_lines) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		assert (n_lines > 0) else begin
			run_errors++;
			$display("no test vectors were read");
		end
		$display("errors: %0d mismatches, %0d extra records, %0d other",
			mismatches, extra_records, run_errors);
		if (mismatches == 0 && extra_records == 0 && run_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		repeat (n_lines * cycles_per_line + 2) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles",
			n_lines * cycles_per_line + 2);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* tests/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen (
	output logic clk,
	output logic reset
);

	initial clk = 1'b0;

	always #2 clk = ~clk; // 4 ns period.

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* hdl/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	output logic                in_ready,
	input  exec_pkg::word_t     in_instr,
	input  exec_pkg::word_t     in_load_word,
	output logic                wb_valid,
	input  logic                wb_ready,
	output exec_pkg::reg_addr_t wb_reg,
	output exec_pkg::word_t     wb_value,
	output logic                wb_illegal,
	output exec_pkg::word_t     v0
);
	import exec_pkg::*;

	reg_addr_t  rd_addr_a;
	reg_addr_t  rd_addr_b;
	word_t      rd_data_a;
	word_t      rd_data_b;
	logic       wr_en;
	reg_addr_t  wr_addr;
	logic [3:0] wr_lanes;
	word_t      wr_data;
	alu_op_t    alu_op;
	word_t      alu_b;
	word_t      alu_result;
	load_kind_t ld_kind;
	logic [1:0] ld_offset;
	word_t      ld_word;
	word_t      ld_merged;

	exec_ctrl ctrl_i (
		.clk,
		.reset,
		.in_valid,
		.in_ready,
		.in_instr,
		.in_load_word,
		.wb_valid,
		.wb_ready,
		.wb_reg,
		.wb_value,
		.wb_illegal,
		.rd_addr_a,
		.rd_addr_b,
		.rd_data_a,
		.rd_data_b,
		.wr_en,
		.wr_addr,
		.wr_lanes,
		.wr_data,
		.alu_op,
		.alu_b,
		.alu_result,
		.ld_kind,
		.ld_offset,
		.ld_word,
		.ld_merged
	);

	reg_file regs_i (
		.clk,
		.reset,
		.rd_addr_a,
		.rd_addr_b,
		.rd_data_a,
		.rd_data_b,
		.wr_en,
		.wr_addr,
		.wr_lanes,
		.wr_data,
		.v0
	);

	alu alu_i (
		.op     (alu_op),
		.a      (rd_data_a), // rs.
		.b      (alu_b),
		.result (alu_result)
	);

	load_merge merge_i (
		.kind      (ld_kind),
		.offset    (ld_offset),
		.mem_word  (ld_word),
		.old_value (rd_data_b), // old rt.
		.merged    (ld_merged)
	);

endmodule

/* hdl/exec_ctrl.sv */
`timescale 1ns/1ns

module exec_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  exec_pkg::word_t      in_instr,
	input  exec_pkg::word_t      in_load_word,
	output logic                 wb_valid,
	input  logic                 wb_ready,
	output exec_pkg::reg_addr_t  wb_reg,
	output exec_pkg::word_t      wb_value,
	output logic                 wb_illegal,
	output exec_pkg::reg_addr_t  rd_addr_a,
	output exec_pkg::reg_addr_t  rd_addr_b,
	input  exec_pkg::word_t      rd_data_a,
	input  exec_pkg::word_t      rd_data_b,
	output logic                 wr_en,
	output exec_pkg::reg_addr_t  wr_addr,
	output logic [3:0]           wr_lanes,
	output exec_pkg::word_t      wr_data,
	output exec_pkg::alu_op_t    alu_op,
	output exec_pkg::word_t      alu_b,
	input  exec_pkg::word_t      alu_result,
	output exec_pkg::load_kind_t ld_kind,
	output logic [1:0]           ld_offset,
	output exec_pkg::word_t      ld_word,
	input  exec_pkg::word_t      ld_merged
);
	import exec_pkg::*;

	typedef enum logic [1:0] {IDLE, READ, EXEC, WB} state_t;

	state_t     state;
	word_t      instr_q;
	word_t      load_word_q;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm;
	reg_addr_t  dest;
	logic       use_imm;
	logic       use_zext;
	logic       use_rd;
	logic       illegal;
	word_t      result;

	assign opcode    = instr_q[31:26];
	assign funct     = instr_q[5:0];
	assign imm       = instr_q[15:0];
	assign rd_addr_a = instr_q[25:21]; // rs.
	assign rd_addr_b = instr_q[20:16]; // rt.

	// ------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------
	always_comb begin
		alu_op   = ALU_ADD;
		ld_kind  = LD_NONE;
		use_imm  = 1'b1;
		use_zext = 1'b0;
		use_rd   = 1'b0;
		illegal  = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				use_imm = 1'b0;
				use_rd  = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					default: illegal = 1'b1;
				endcase
			end
			OP_ADDIU: alu_op = ALU_ADD;
			OP_ORI: begin
				alu_op   = ALU_OR;
				use_zext = 1'b1;
			end
			OP_LUI: begin
				alu_op   = ALU_LUI;
				use_zext = 1'b1;
			end
			OP_LW:   ld_kind = LD_W;
			OP_LWL:  ld_kind = LD_WL;
			OP_LWR:  ld_kind = LD_WR;
			default: illegal = 1'b1;
		endcase
	end

	always_comb begin
		if (!use_imm) begin
			alu_b = rd_data_b;
		end else if (use_zext) begin
			alu_b = {16'h0000, imm};
		end else begin
			alu_b = {{16{imm[15]}}, imm};
		end
	end

	assign dest      = use_rd ? instr_q[15:11] : instr_q[20:16];
	assign ld_offset = alu_result[1:0]; // low bits of the load address.
	assign ld_word   = load_word_q;
	assign result    = (ld_kind != LD_NONE) ? ld_merged : alu_result;

	// ------------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    if (in_valid) state <= READ;
				READ:    state <= EXEC;
				EXEC:    state <= WB;
				default: if (wb_ready) state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			instr_q     <= in_instr;
			load_word_q <= in_load_word;
		end
		if (state == EXEC) begin
			wb_reg     <= illegal ? 5'd0 : dest;
			wb_value   <= illegal ? '0 : result;
			wb_illegal <= illegal;
		end
	end

	assign in_ready = (state == IDLE);
	assign wb_valid = (state == WB);

	// write lands on the output transfer edge.
	assign wr_en    = wb_valid && wb_ready && !wb_illegal;
	assign wr_addr  = wb_reg;
	assign wr_lanes = 4'b1111; // merge already done.
	assign wr_data  = wb_value;

endmodule

/* hdl/load_merge.sv */
`timescale 1ns/1ns

module load_merge (
	input  exec_pkg::load_kind_t kind,
	input  logic [1:0]           offset,
	input  exec_pkg::word_t      mem_word,
	input  exec_pkg::word_t      old_value,
	output exec_pkg::word_t      merged
);
	import exec_pkg::*;

	word_t      shifted;
	logic [3:0] lanes; // bit 3 is the msb byte.

	// big-endian, so offset 0 addresses the msb byte.
	always_comb begin
		shifted = mem_word;
		lanes   = 4'b0000;
		case (kind)
			LD_W: begin
				lanes = 4'b1111;
			end
			LD_WL: begin
				shifted = mem_word << (8 * offset);
				lanes   = 4'b1111 << offset;
			end
			LD_WR: begin
				shifted = mem_word >> (8 * (2'd3 - offset));
				lanes   = 4'b1111 >> (2'd3 - offset);
			end
			default: begin
				lanes = 4'b0000; // old value passes.
			end
		endcase
	end

	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			if (lanes[lane]) begin
				merged[8*lane +: 8] = shifted[8*lane +: 8];
			end else begin
				merged[8*lane +: 8] = old_value[8*lane +: 8];
			end
		end
	end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu (
	input  exec_pkg::alu_op_t op,
	input  exec_pkg::word_t   a,
	input  exec_pkg::word_t   b,
	output exec_pkg::word_t   result
);
	import exec_pkg::*;

	word_t sum;
	word_t diff;
	logic  less;

	assign sum  = a + b;
	assign diff = a - b;

	// signed compare from the subtraction and the operand signs.
	always_comb begin
		if (a[31] != b[31]) begin
			less = a[31];
		end else begin
			less = diff[31];
		end
	end

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = sum;
			end
			ALU_SUB: begin
				result = diff;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			ALU_SLT: begin
				result = {31'd0, less};
			end
			ALU_LUI: begin
				result = {b[15:0], 16'h0000}; // upper half from imm.
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
	input  logic                clk,
	input  logic                reset,
	input  exec_pkg::reg_addr_t rd_addr_a,
	input  exec_pkg::reg_addr_t rd_addr_b,
	output exec_pkg::word_t     rd_data_a,
	output exec_pkg::word_t     rd_data_b,
	input  logic                wr_en,
	input  exec_pkg::reg_addr_t wr_addr,
	input  logic [3:0]          wr_lanes,
	input  exec_pkg::word_t     wr_data,
	output exec_pkg::word_t     v0
);
	import exec_pkg::*;

	word_t regs [32];

	// ------------------------------------------------------------------
	// write port with byte lanes
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != 5'd0)) begin // r0 stays zero.
			for (int lane = 0; lane < 4; lane++) begin
				if (wr_lanes[lane]) begin
					regs[wr_addr][8*lane +: 8] <= wr_data[8*lane +: 8];
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// registered read ports
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		rd_data_a <= regs[rd_addr_a];
		rd_data_b <= regs[rd_addr_b];
	end

	assign v0 = regs[2]; // v0 for the top level.

endmodule

/* hdl/exec_pkg.sv */
package exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// ------------------------------------------------------------------
	// primary opcodes, instr[31:26]
	// ------------------------------------------------------------------
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LWL   = 6'h22;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_LWR   = 6'h26;

	// ------------------------------------------------------------------
	// funct field of R-type, instr[5:0]
	// ------------------------------------------------------------------
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	// LD_NONE marks a non-load instruction.
	typedef enum logic [1:0] {
		LD_NONE,
		LD_W,
		LD_WL,
		LD_WR
	} load_kind_t;

endpackage
